/* digital_core_pkg.sv */
//----------------------------------------
// digital core shared definitions
//----------------------------------------
package digital_core_pkg;

    //----------------------------------------
    // bus widths
    //----------------------------------------
    localparam int WB_WIDTH  = 32;      // data and address width
    localparam int WB_SEL_W  = 4;       // byte enables
    localparam int BANK_W    = 8;       // bank byte on top of internal address
    localparam int REG_OFF_W = 8;       // register offset decode width

    //----------------------------------------
    // address map
    //----------------------------------------
    localparam int HOST_SPACE_BIT = 23; // set -> host registers, clear -> internal

    // host register offsets
    localparam logic [REG_OFF_W-1:0] HOST_BANK_OFF      = 8'h00; // bank select, 8 bit
    localparam logic [REG_OFF_W-1:0] HOST_GLB_CTRL_OFF  = 8'h04; // global control, 8 bit
    localparam logic [REG_OFF_W-1:0] HOST_CLK_CTRL1_OFF = 8'h08; // clock skew selects

    // global register block
    localparam logic [BANK_W-1:0]    GLBL_BANK        = 8'h10;
    localparam logic [REG_OFF_W-1:0] GLBL_ID_OFF      = 8'h00; // read only
    localparam logic [REG_OFF_W-1:0] GLBL_SCRATCH_OFF = 8'h04;
    localparam logic [REG_OFF_W-1:0] GLBL_IRQ_OFF     = 8'h08; // 3 bit user irq

    //----------------------------------------
    // global control register
    //----------------------------------------
    // first field lands on the msb, so wbd_int_rst_n is bit 0
    typedef struct packed {
        logic [3:0] spare;
        logic       sdram_rst_n;    // bit 3
        logic       spi_rst_n;      // bit 2
        logic       cpu_rst_n;      // bit 1
        logic       wbd_int_rst_n;  // bit 0, internal bus reset
    } glb_ctrl_t;

    localparam logic [7:0] RST_CTRL_DEF = 8'h00; // everything held in reset

endpackage : digital_core_pkg

/* wb_if.sv */
//----------------------------------------
// internal wishbone bus
//----------------------------------------
`timescale 1ns/1ns

interface wb_if;

    // request
    logic                                   cyc;
    logic                                   stb;
    logic [digital_core_pkg::WB_WIDTH-1:0]  adr;
    logic                                   we;
    logic [digital_core_pkg::WB_WIDTH-1:0]  dat_w;
    logic [digital_core_pkg::WB_SEL_W-1:0]  sel;

    // response
    logic [digital_core_pkg::WB_WIDTH-1:0]  dat_r;
    logic                                   ack;    // one cycle per request
    logic                                   err;    // one cycle, instead of ack

    // request held until ack or err
    modport master (
        output cyc, stb, adr, we, dat_w, sel,
        input  dat_r, ack, err
    );

    modport slave (
        input  cyc, stb, adr, we, dat_w, sel,
        output dat_r, ack, err
    );

endinterface : wb_if

/* wb_host.sv */
//----------------------------------------
// wishbone host bridge
//----------------------------------------
`timescale 1ns/1ns

module wb_host (
    input  logic                                   wb_clk_i,
    input  logic                                   arst_n_i,

    // external host port
    input  logic                                   wbs_cyc_i,
    input  logic                                   wbs_stb_i,
    input  logic [digital_core_pkg::WB_WIDTH-1:0]  wbs_adr_i,
    input  logic                                   wbs_we_i,
    input  logic [digital_core_pkg::WB_WIDTH-1:0]  wbs_dat_i,
    input  logic [digital_core_pkg::WB_SEL_W-1:0]  wbs_sel_i,
    output logic [digital_core_pkg::WB_WIDTH-1:0]  wbs_dat_o,
    output logic                                   wbs_ack_o,
    output logic                                   wbs_err_o,

    wb_if.master                                   bus_m,      // internal bus

    output digital_core_pkg::glb_ctrl_t            cfg_glb_ctrl_o,
    output logic [31:0]                            cfg_clk_ctrl1_o
);

    logic                                   accept;     // new external request taken
    logic                                   host_sel;   // targets host registers
    logic                                   host_hit;   // valid host offset
    logic                                   int_start;  // launch onto internal bus
    logic                                   int_done;   // internal response back
    logic [digital_core_pkg::REG_OFF_W-1:0] reg_off;
    logic [digital_core_pkg::WB_WIDTH-1:0]  host_rdata;

    logic [digital_core_pkg::BANK_W-1:0]    bank_q;
    digital_core_pkg::glb_ctrl_t            glb_ctrl_q;
    logic [31:0]                            clk_ctrl1_q;

    logic                                   m_stb_q;    // also serves as busy
    logic                                   m_we_q;
    logic [digital_core_pkg::WB_WIDTH-1:0]  m_adr_q;
    logic [digital_core_pkg::WB_WIDTH-1:0]  m_dat_q;
    logic [digital_core_pkg::WB_SEL_W-1:0]  m_sel_q;
    logic                                   ack_q;
    logic                                   err_q;
    logic [digital_core_pkg::WB_WIDTH-1:0]  dat_q;

    // no new request while one is in flight or being answered
    assign accept    = wbs_cyc_i & wbs_stb_i & ~m_stb_q & ~ack_q & ~err_q;
    assign host_sel  = wbs_adr_i[digital_core_pkg::HOST_SPACE_BIT];
    assign int_start = accept & ~host_sel & glb_ctrl_q.wbd_int_rst_n;
    assign int_done  = m_stb_q & (bus_m.ack | bus_m.err);
    assign reg_off   = wbs_adr_i[digital_core_pkg::REG_OFF_W-1:0];

    // host register read mux
    always_comb begin
        host_hit   = 1'b1;
        host_rdata = '0;
        case (reg_off)
            digital_core_pkg::HOST_BANK_OFF:      host_rdata[7:0] = bank_q;
            digital_core_pkg::HOST_GLB_CTRL_OFF:  host_rdata[7:0] = glb_ctrl_q;
            digital_core_pkg::HOST_CLK_CTRL1_OFF: host_rdata      = clk_ctrl1_q;
            default:                              host_hit        = 1'b0;
        endcase
    end

    //----------------------------------------
    // control and config registers
    //----------------------------------------
    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q       <= 1'b0;
            err_q       <= 1'b0;
            m_stb_q     <= 1'b0;
            bank_q      <= '0;
            glb_ctrl_q  <= digital_core_pkg::RST_CTRL_DEF;
            clk_ctrl1_q <= '0;
        end else begin
            ack_q <= 1'b0;  // single cycle pulses
            err_q <= 1'b0;
            if (accept) begin
                if (host_sel) begin
                    ack_q <= host_hit;
                    err_q <= ~host_hit;
                end else if (!glb_ctrl_q.wbd_int_rst_n) begin
                    ack_q <= 1'b1;  // internal bus in reset, answer locally
                end else begin
                    m_stb_q <= 1'b1;
                end
            end else if (int_done) begin
                m_stb_q <= 1'b0;
                ack_q   <= bus_m.ack;   // forward one cycle later
                err_q   <= bus_m.err;
            end

            if (accept && host_sel && wbs_we_i) begin
                case (reg_off)
                    digital_core_pkg::HOST_BANK_OFF:
                        if (wbs_sel_i[0]) bank_q <= wbs_dat_i[7:0];
                    digital_core_pkg::HOST_GLB_CTRL_OFF:
                        if (wbs_sel_i[0]) glb_ctrl_q <= wbs_dat_i[7:0];
                    digital_core_pkg::HOST_CLK_CTRL1_OFF:
                        for (int b = 0; b < digital_core_pkg::WB_SEL_W; b++) begin
                            if (wbs_sel_i[b]) clk_ctrl1_q[8*b +: 8] <= wbs_dat_i[8*b +: 8];
                        end
                    default: ;      // err, nothing written
                endcase
            end
        end
    end

    // payload
    always_ff @(posedge wb_clk_i) begin
        if (int_start) begin
            // bank byte on top of the 24 bit window
            m_adr_q <= {bank_q, wbs_adr_i[digital_core_pkg::WB_WIDTH-digital_core_pkg::BANK_W-1:0]};
            m_we_q  <= wbs_we_i;
            m_dat_q <= wbs_dat_i;
            m_sel_q <= wbs_sel_i;
        end
        if (accept) begin
            dat_q <= host_sel ? host_rdata : '0;
        end else if (int_done) begin
            dat_q <= bus_m.dat_r;
        end
    end

    assign bus_m.cyc   = m_stb_q;
    assign bus_m.stb   = m_stb_q;
    assign bus_m.adr   = m_adr_q;
    assign bus_m.we    = m_we_q;
    assign bus_m.dat_w = m_dat_q;
    assign bus_m.sel   = m_sel_q;

    assign wbs_dat_o       = dat_q;
    assign wbs_ack_o       = ack_q;
    assign wbs_err_o       = err_q;
    assign cfg_glb_ctrl_o  = glb_ctrl_q;
    assign cfg_clk_ctrl1_o = clk_ctrl1_q;

endmodule : wb_host

/* wb_stagging.sv */
//----------------------------------------
// wishbone staging flops
//----------------------------------------
`timescale 1ns/1ns

module wb_stagging (
    input  logic wb_clk_i,
    input  logic arst_n_i,     // internal bus reset
    wb_if.slave  bus_s,        // from host bridge
    wb_if.master bus_m         // to register block
);

    logic                                   accept;
    logic                                   rsp_seen;

    logic                                   m_stb_q;    // request issued downstream
    logic                                   m_we_q;
    logic [digital_core_pkg::WB_WIDTH-1:0]  m_adr_q;
    logic [digital_core_pkg::WB_WIDTH-1:0]  m_dat_q;
    logic [digital_core_pkg::WB_SEL_W-1:0]  m_sel_q;

    logic                                   s_ack_q;    // response back upstream
    logic                                   s_err_q;
    logic [digital_core_pkg::WB_WIDTH-1:0]  s_dat_q;

    // upstream stb is still high while its ack is out, so block that cycle too
    assign accept   = bus_s.cyc & bus_s.stb & ~m_stb_q & ~s_ack_q & ~s_err_q;
    assign rsp_seen = m_stb_q & (bus_m.ack | bus_m.err);

    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            m_stb_q <= 1'b0;
            s_ack_q <= 1'b0;
            s_err_q <= 1'b0;
        end else begin
            s_ack_q <= 1'b0;
            s_err_q <= 1'b0;
            if (accept) begin
                m_stb_q <= 1'b1;
            end else if (rsp_seen) begin
                m_stb_q <= 1'b0;        // issued once only
                s_ack_q <= bus_m.ack;
                s_err_q <= bus_m.err;
            end
        end
    end

    // request and response payload
    always_ff @(posedge wb_clk_i) begin
        if (accept) begin
            m_adr_q <= bus_s.adr;
            m_we_q  <= bus_s.we;
            m_dat_q <= bus_s.dat_w;
            m_sel_q <= bus_s.sel;
        end
        if (rsp_seen) s_dat_q <= bus_m.dat_r;
    end

    assign bus_m.cyc   = m_stb_q;
    assign bus_m.stb   = m_stb_q;
    assign bus_m.adr   = m_adr_q;
    assign bus_m.we    = m_we_q;
    assign bus_m.dat_w = m_dat_q;
    assign bus_m.sel   = m_sel_q;

    assign bus_s.dat_r = s_dat_q;
    assign bus_s.ack   = s_ack_q;
    assign bus_s.err   = s_err_q;

endmodule : wb_stagging

/* glbl_cfg.sv */
//----------------------------------------
// global register block
//----------------------------------------
`timescale 1ns/1ns

module glbl_cfg #(
    parameter logic [31:0] DEVICE_ID = 32'h5946_0001   // read back at GLBL_ID_OFF
) (
    input  logic       wb_clk_i,
    input  logic       arst_n_i,     // internal bus reset
    wb_if.slave        bus_s,
    output logic [2:0] user_irq_o
);

    logic                                   req;        // new request this cycle
    logic                                   hit;        // bank and offset mapped
    logic                                   bank_ok;
    logic [digital_core_pkg::BANK_W-1:0]    bank;
    logic [digital_core_pkg::REG_OFF_W-1:0] reg_off;
    logic [digital_core_pkg::WB_WIDTH-1:0]  rdata;

    logic [31:0]                            scratch_q;
    logic [2:0]                             irq_q;
    logic                                   ack_q;
    logic                                   err_q;
    logic [digital_core_pkg::WB_WIDTH-1:0]  dat_q;

    // stb still high in the ack cycle, do not answer twice
    assign req     = bus_s.cyc & bus_s.stb & ~ack_q & ~err_q;
    assign bank    = bus_s.adr[digital_core_pkg::WB_WIDTH-1 -: digital_core_pkg::BANK_W];
    assign reg_off = bus_s.adr[digital_core_pkg::REG_OFF_W-1:0];
    assign bank_ok = (bank == digital_core_pkg::GLBL_BANK);

    //----------------------------------------
    // address decode and read mux
    //----------------------------------------
    always_comb begin
        hit   = bank_ok;
        rdata = '0;
        case (reg_off)
            digital_core_pkg::GLBL_ID_OFF:      rdata      = DEVICE_ID;
            digital_core_pkg::GLBL_SCRATCH_OFF: rdata      = scratch_q;
            digital_core_pkg::GLBL_IRQ_OFF:     rdata[2:0] = irq_q;
            default:                            hit        = 1'b0;
        endcase
        if (!bank_ok) rdata = '0;   // other bank reads nothing
    end

    // handshake
    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q <= 1'b0;
            err_q <= 1'b0;
        end else begin
            ack_q <= req & hit;
            err_q <= req & ~hit;    // unmapped, registers untouched
        end
    end

    //----------------------------------------
    // writable registers
    //----------------------------------------
    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            scratch_q <= '0;
            irq_q     <= '0;
        end else if (req && hit && bus_s.we) begin
            case (reg_off)
                digital_core_pkg::GLBL_SCRATCH_OFF:
                    for (int b = 0; b < digital_core_pkg::WB_SEL_W; b++) begin
                        if (bus_s.sel[b]) scratch_q[8*b +: 8] <= bus_s.dat_w[8*b +: 8];
                    end
                digital_core_pkg::GLBL_IRQ_OFF:
                    if (bus_s.sel[0]) irq_q <= bus_s.dat_w[2:0];
                default: ;          // id is read only
            endcase
        end
    end

    // read data, held with the ack
    always_ff @(posedge wb_clk_i) begin
        if (req) dat_q <= rdata;
    end

    assign bus_s.dat_r = dat_q;
    assign bus_s.ack   = ack_q;
    assign bus_s.err   = err_q;
    assign user_irq_o  = irq_q;

endmodule : glbl_cfg

/* digital_core.sv */
//----------------------------------------
// digital core top
//----------------------------------------
`timescale 1ns/1ns

module digital_core #(
    parameter logic [31:0] DEVICE_ID = 32'h5946_0001
) (
    input  logic                                   wb_clk_i,
    input  logic                                   arst_n_i,

    // host wishbone port
    input  logic                                   wbs_cyc_i,
    input  logic                                   wbs_stb_i,
    input  logic                                   wbs_we_i,
    input  logic [digital_core_pkg::WB_WIDTH-1:0]  wbs_adr_i,
    input  logic [digital_core_pkg::WB_WIDTH-1:0]  wbs_dat_i,
    input  logic [digital_core_pkg::WB_SEL_W-1:0]  wbs_sel_i,
    output logic [digital_core_pkg::WB_WIDTH-1:0]  wbs_dat_o,
    output logic                                   wbs_ack_o,
    output logic                                   wbs_err_o,

    // reset control
    output logic                                   cpu_rst_n_o,
    output logic                                   spi_rst_n_o,
    output logic                                   sdram_rst_n_o,

    output logic [31:0]                            cfg_clk_ctrl1_o,  // seven 4 bit skew selects
    output logic [2:0]                             user_irq_o
);

    digital_core_pkg::glb_ctrl_t cfg_glb_ctrl;
    logic                        wbd_int_rst_n;   // internal bus reset, from host

    wb_if host_bus ();   // host -> staging
    wb_if glbl_bus ();   // staging -> global regs

    //----------------------------------------
    // reset control split
    //----------------------------------------
    assign wbd_int_rst_n = cfg_glb_ctrl.wbd_int_rst_n;
    assign cpu_rst_n_o   = cfg_glb_ctrl.cpu_rst_n;
    assign spi_rst_n_o   = cfg_glb_ctrl.spi_rst_n;
    assign sdram_rst_n_o = cfg_glb_ctrl.sdram_rst_n;

    wb_host u_wb_host (
        .wb_clk_i        (wb_clk_i),
        .arst_n_i        (arst_n_i),
        .wbs_cyc_i       (wbs_cyc_i),
        .wbs_stb_i       (wbs_stb_i),
        .wbs_adr_i       (wbs_adr_i),
        .wbs_we_i        (wbs_we_i),
        .wbs_dat_i       (wbs_dat_i),
        .wbs_sel_i       (wbs_sel_i),
        .wbs_dat_o       (wbs_dat_o),
        .wbs_ack_o       (wbs_ack_o),
        .wbs_err_o       (wbs_err_o),
        .bus_m           (host_bus.master),
        .cfg_glb_ctrl_o  (cfg_glb_ctrl),
        .cfg_clk_ctrl1_o (cfg_clk_ctrl1_o)
    );

    // breaks the host to register path
    wb_stagging u_wb_stagging (
        .wb_clk_i (wb_clk_i),
        .arst_n_i (wbd_int_rst_n),
        .bus_s    (host_bus.slave),
        .bus_m    (glbl_bus.master)
    );

    glbl_cfg #(
        .DEVICE_ID (DEVICE_ID)
    ) u_glbl_cfg (
        .wb_clk_i   (wb_clk_i),
        .arst_n_i   (wbd_int_rst_n),
        .bus_s      (glbl_bus.slave),
        .user_irq_o (user_irq_o)
    );

endmodule : digital_core

/* digital_core_checker.sv */
//----------------------------------------
// host port handshake checks
//----------------------------------------
`timescale 1ns/1ns

module digital_core_checker (
    input logic clk_i,
    input logic arst_n_i,
    input logic cyc_i,
    input logic stb_i,
    input logic ack_i,
    input logic err_i
);

    // never both at once
    a_ack_err_excl: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(ack_i && err_i))
        else $error("ack and err high in the same cycle");

    a_ack_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        ack_i |=> !ack_i)
        else $error("ack held longer than one cycle");

    a_err_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        err_i |=> !err_i)
        else $error("err held longer than one cycle");

    // request stays up until answered
    a_stb_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (cyc_i && stb_i && !ack_i && !err_i) |=> (cyc_i && stb_i))
        else $error("stb dropped before the response");

    a_rsp_has_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (ack_i || err_i) |-> (cyc_i && stb_i))
        else $error("response without a request");

endmodule : digital_core_checker

/* tb_digital_core.sv */
//----------------------------------------
// digital core testbench
//----------------------------------------
`timescale 1ns/1ns

module tb_digital_core;

    localparam logic [31:0] DEVICE_ID = 32'h00a5_1c3d;
    localparam int          RAND_SEED = 32'h4fb91e4b;
    localparam int          N_HOST    = 9;      // host register write/read pairs
    localparam int          N_SCR     = 12;     // scratch write/read pairs
    localparam int          N_IRQ     = 4;
    // reset read, host regs, bring up, scratch, irq, error cases
    localparam int          N_TXN     = 1 + 2*N_HOST + 3 + 2*N_SCR + 2*N_IRQ + 8;
    localparam int          TIMEOUT_CYC = 20 * N_TXN;

    localparam logic [31:0] HOST_BASE = 32'h0080_0000;  // bit 23 set
    localparam logic [31:0] BANK_ADR  = HOST_BASE | {24'h0, digital_core_pkg::HOST_BANK_OFF};
    localparam logic [31:0] GLB_ADR   = HOST_BASE | {24'h0, digital_core_pkg::HOST_GLB_CTRL_OFF};
    localparam logic [31:0] ID_ADR    = {24'h0, digital_core_pkg::GLBL_ID_OFF};
    localparam logic [31:0] SCR_ADR   = {24'h0, digital_core_pkg::GLBL_SCRATCH_OFF};
    localparam logic [31:0] IRQ_ADR   = {24'h0, digital_core_pkg::GLBL_IRQ_OFF};
    localparam logic [31:0] BAD_OFF   = 32'h0000_000c;  // not mapped anywhere

    logic        clk;
    logic        arst_n;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [31:0] adr;
    logic [31:0] dat_w;
    logic [3:0]  sel;
    logic [31:0] dat_r;
    logic        ack;
    logic        err;
    logic        cpu_rst_n;
    logic        spi_rst_n;
    logic        sdram_rst_n;
    logic [31:0] clk_ctrl1;
    logic [2:0]  user_irq;

    // register model
    logic [7:0]  m_bank;
    logic [7:0]  m_glb;
    logic [31:0] m_clk;
    logic [31:0] m_scratch;
    logic [2:0]  m_irq;

    logic [33:0] exp_q[$];      // {is read, err, data} per access
    int          cycle_cnt = 0;

    digital_core #(
        .DEVICE_ID (DEVICE_ID)
    ) digital_core_inst (
        .wb_clk_i        (clk),
        .arst_n_i        (arst_n),
        .wbs_cyc_i       (cyc),
        .wbs_stb_i       (stb),
        .wbs_we_i        (we),
        .wbs_adr_i       (adr),
        .wbs_dat_i       (dat_w),
        .wbs_sel_i       (sel),
        .wbs_dat_o       (dat_r),
        .wbs_ack_o       (ack),
        .wbs_err_o       (err),
        .cpu_rst_n_o     (cpu_rst_n),
        .spi_rst_n_o     (spi_rst_n),
        .sdram_rst_n_o   (sdram_rst_n),
        .cfg_clk_ctrl1_o (clk_ctrl1),
        .user_irq_o      (user_irq)
    );

    bind digital_core digital_core_checker digital_core_chk (
        .clk_i    (wb_clk_i),
        .arst_n_i (arst_n_i),
        .cyc_i    (wbs_cyc_i),
        .stb_i    (wbs_stb_i),
        .ack_i    (wbs_ack_o),
        .err_i    (wbs_err_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;      // 4 ns period
    end

    //----------------------------------------
    // reference model
    //----------------------------------------
    function automatic logic [31:0] ref_read(input logic [31:0] a, output logic exp_err);
        logic [31:0] d;
        d       = '0;
        exp_err = 1'b0;
        if (a[digital_core_pkg::HOST_SPACE_BIT]) begin
            case (a[7:0])
                digital_core_pkg::HOST_BANK_OFF:      d[7:0] = m_bank;
                digital_core_pkg::HOST_GLB_CTRL_OFF:  d[7:0] = m_glb;
                digital_core_pkg::HOST_CLK_CTRL1_OFF: d      = m_clk;
                default:                              exp_err = 1'b1;
            endcase
        end else if (m_glb[0]) begin            // internal bus out of reset
            if (m_bank != digital_core_pkg::GLBL_BANK) begin
                exp_err = 1'b1;
            end else begin
                case (a[7:0])
                    digital_core_pkg::GLBL_ID_OFF:      d      = DEVICE_ID;
                    digital_core_pkg::GLBL_SCRATCH_OFF: d      = m_scratch;
                    digital_core_pkg::GLBL_IRQ_OFF:     d[2:0] = m_irq;
                    default:                            exp_err = 1'b1;
                endcase
            end
        end
        return d;   // zero while the internal bus is in reset
    endfunction

    task automatic model_write(input logic [31:0] a, input logic [31:0] d, input logic [3:0] s);
        if (a[digital_core_pkg::HOST_SPACE_BIT]) begin
            case (a[7:0])
                digital_core_pkg::HOST_BANK_OFF:     if (s[0]) m_bank = d[7:0];
                digital_core_pkg::HOST_GLB_CTRL_OFF: if (s[0]) m_glb = d[7:0];
                default:
                    for (int b = 0; b < 4; b++) begin
                        if (s[b]) m_clk[8*b +: 8] = d[8*b +: 8];
                    end
            endcase
            if (!m_glb[0]) begin        // global regs held in reset with the bus
                m_scratch = '0;
                m_irq     = '0;
            end
        end else if (m_glb[0]) begin
            if (a[7:0] == digital_core_pkg::GLBL_SCRATCH_OFF) begin
                for (int b = 0; b < 4; b++) begin
                    if (s[b]) m_scratch[8*b +: 8] = d[8*b +: 8];
                end
            end else if (a[7:0] == digital_core_pkg::GLBL_IRQ_OFF && s[0]) begin
                m_irq = d[2:0];
            end
        end
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            $display("Error at time %0t: %s is 0x%h, expected 0x%h", $time, name, got, want);
            $display("ERRORS FOUND");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    //----------------------------------------
    // bus access
    //----------------------------------------
    task automatic bus_xfer(input logic wr, input logic [31:0] a, input logic [31:0] d,
                            input logic [3:0] s);
        @(posedge clk);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= wr;
        adr   <= a;
        dat_w <= d;
        sel   <= s;
        @(negedge clk);
        while (!(ack || err)) @(negedge clk);  // held until the response
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
    endtask

    task automatic access(input logic wr, input logic [31:0] a, input logic [31:0] d,
                          input logic [3:0] s);
        logic        exp_err;
        logic [31:0] exp_dat;
        exp_dat = ref_read(a, exp_err);
        exp_q.push_back({~wr, exp_err, exp_dat});
        if (wr && !exp_err) model_write(a, d, s);
        bus_xfer(wr, a, d, s);
    endtask

    // response and side outputs against the model
    always @(negedge clk) begin : compare
        logic [33:0] expct;
        if (arst_n && (ack || err)) begin
            if (exp_q.size() == 0) begin
                $display("DUT answered with no access outstanding");
                $display("ERRORS FOUND");
                $fatal(1, "unexpected response");
            end else begin
                expct = exp_q.pop_front();
                check_eq("wbs_err_o", {31'b0, err}, {31'b0, expct[32]});
                if (expct[33] && !expct[32]) check_eq("wbs_dat_o", dat_r, expct[31:0]);
                check_eq("cfg_clk_ctrl1_o", clk_ctrl1, m_clk);
                check_eq("cpu_rst_n_o", {31'b0, cpu_rst_n}, {31'b0, m_glb[1]});
                check_eq("spi_rst_n_o", {31'b0, spi_rst_n}, {31'b0, m_glb[2]});
                check_eq("sdram_rst_n_o", {31'b0, sdram_rst_n}, {31'b0, m_glb[3]});
                check_eq("user_irq_o", {29'b0, user_irq}, {29'b0, m_irq});
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYC) begin
            $display("Timeout after %0d cycles, DUT stopped answering", cycle_cnt);
            $display("ERRORS FOUND");
            $fatal(1, "timeout");
        end
    end

    //----------------------------------------
    // stimulus
    //----------------------------------------
    initial begin
        logic [31:0] r;
        logic [31:0] d;
        logic [31:0] a;
        cyc       = 1'b0;
        stb       = 1'b0;
        we        = 1'b0;
        adr       = '0;
        dat_w     = '0;
        sel       = '0;
        arst_n    = 1'b0;
        m_bank    = '0;
        m_glb     = digital_core_pkg::RST_CTRL_DEF;
        m_clk     = '0;
        m_scratch = '0;
        m_irq     = '0;
        r         = $urandom(RAND_SEED);    // seed once
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;

        // internal read while the bus is still in reset
        access(1'b0, ID_ADR, '0, 4'hf);

        // host registers
        for (int i = 0; i < N_HOST; i++) begin
            r = $urandom_range(2);
            a = HOST_BASE | {r[29:0], 2'b00};
            d = $urandom();
            r = $urandom();
            access(1'b1, a, d, r[3:0]);
            access(1'b0, a, '0, 4'hf);
        end

        // release internal reset, select global bank
        access(1'b1, GLB_ADR, 32'h0000_000f, 4'h1);
        access(1'b1, BANK_ADR, {24'h0, digital_core_pkg::GLBL_BANK}, 4'hf);
        access(1'b0, ID_ADR, '0, 4'hf);

        for (int i = 0; i < N_SCR; i++) begin
            d = $urandom();
            r = $urandom();
            access(1'b1, SCR_ADR, d, r[3:0]);
            access(1'b0, SCR_ADR, '0, 4'hf);
        end
        for (int i = 0; i < N_IRQ; i++) begin
            d = $urandom();
            access(1'b1, IRQ_ADR, d, 4'h1);
            access(1'b0, IRQ_ADR, '0, 4'hf);
        end

        // unmapped offsets and a foreign bank
        access(1'b0, BAD_OFF, '0, 4'hf);
        access(1'b1, BAD_OFF, 32'hffff_ffff, 4'hf);
        access(1'b0, HOST_BASE | BAD_OFF, '0, 4'hf);
        access(1'b1, BANK_ADR, 32'h0000_0011, 4'h1);
        access(1'b1, SCR_ADR, 32'h1234_5678, 4'hf);
        access(1'b0, SCR_ADR, '0, 4'hf);
        access(1'b1, BANK_ADR, {24'h0, digital_core_pkg::GLBL_BANK}, 4'h1);
        access(1'b0, SCR_ADR, '0, 4'hf);

        @(posedge clk);
        if (exp_q.size() != 0) begin
            $display("%0d accesses never answered", exp_q.size());
            $display("ERRORS FOUND");
            $fatal(1, "missing responses");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule : tb_digital_core

/* vlog.f */
digital_core_pkg.sv
wb_if.sv
wb_host.sv
wb_stagging.sv
glbl_cfg.sv
digital_core.sv
digital_core_checker.sv
tb_digital_core.sv

/* Makefile */
# Verilator build for the digital core testbench
SIM      := verilator
TOP      := tb_digital_core
FILELIST := vlog.f
MDIR     := obj_dir
FLAGS    := --binary --timing --assert --timescale 1ns/1ns -j 0

SRCS     := $(shell cat $(FILELIST))
BIN      := $(MDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(MDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(MDIR)
